// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - hdl/rv_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/ex_alu.sv
      - hdl/ex_branch_unit.sv
      - hdl/ex_pipe_reg.sv
      - hdl/ex_stage.sv
  - target: test
    files:
      - tb/tb_ex_stage.sv

// File: ex_stage.f
hdl/rv_pkg.sv
hdl/pipe_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_pipe_reg.sv
hdl/ex_stage.sv
tb/tb_ex_stage.sv

// File: hdl/ex_alu.sv
`default_nettype none

module ex_alu (
	input  rv_pkg::alu_op_e alu_op,
	input  rv_pkg::data_t   src_a,
	input  rv_pkg::data_t   src_b,
	output rv_pkg::data_t   alu_result
);

	localparam int ext_width = rv_pkg::xlen - rv_pkg::word_width;

	logic [rv_pkg::word_width-1:0] word_a;
	logic [rv_pkg::word_width-1:0] word_b;
	logic [rv_pkg::word_width-1:0] word_res;
	rv_pkg::data_t                 full_res;
	logic                          is_word;

	assign word_a = src_a[rv_pkg::word_width-1:0];
	assign word_b = src_b[rv_pkg::word_width-1:0];

	always_comb begin
		word_res = '0;
		full_res = '0;
		is_word  = 1'b0;
		case (alu_op)
			rv_pkg::alu_add: begin
				full_res = src_a + src_b;
			end
			rv_pkg::alu_sub: begin
				full_res = src_a - src_b;
			end
			rv_pkg::alu_sll: begin
				full_res = src_a << src_b[5:0];
			end
			rv_pkg::alu_srl: begin
				full_res = src_a >> src_b[5:0];
			end
			rv_pkg::alu_sra: begin
				full_res = $signed(src_a) >>> src_b[5:0];
			end
			rv_pkg::alu_and: begin
				full_res = src_a & src_b;
			end
			rv_pkg::alu_or: begin
				full_res = src_a | src_b;
			end
			rv_pkg::alu_xor: begin
				full_res = src_a ^ src_b;
			end
			rv_pkg::alu_slt: begin
				full_res = rv_pkg::data_t'($signed(src_a) < $signed(src_b));
			end
			rv_pkg::alu_sltu: begin
				full_res = rv_pkg::data_t'(src_a < src_b);
			end
			rv_pkg::alu_eq: begin
				full_res = rv_pkg::data_t'(src_a == src_b);
			end
			rv_pkg::alu_ne: begin
				full_res = rv_pkg::data_t'(src_a != src_b);
			end
			rv_pkg::alu_sge: begin
				full_res = rv_pkg::data_t'($signed(src_a) >= $signed(src_b));
			end
			rv_pkg::alu_sgeu: begin
				full_res = rv_pkg::data_t'(src_a >= src_b);
			end
			rv_pkg::alu_addw: begin
				is_word  = 1'b1;
				word_res = word_a + word_b;
			end
			rv_pkg::alu_subw: begin
				is_word  = 1'b1;
				word_res = word_a - word_b;
			end
			rv_pkg::alu_sllw: begin
				is_word  = 1'b1;
				word_res = word_a << src_b[4:0];
			end
			rv_pkg::alu_srlw: begin
				is_word  = 1'b1;
				word_res = word_a >> src_b[4:0];
			end
			rv_pkg::alu_sraw: begin
				is_word  = 1'b1;
				word_res = $signed(word_a) >>> src_b[4:0];
			end
			default: begin
				full_res = '0; // unused codes read as zero
			end
		endcase
	end

	// word results are sign extended from bit 31
	assign alu_result = is_word ? {{ext_width{word_res[rv_pkg::word_width-1]}}, word_res}
		: full_res;

endmodule

`default_nettype wire

// File: hdl/ex_branch_unit.sv
`default_nettype none

module ex_branch_unit (
	input  rv_pkg::insn_t     insn,
	input  rv_pkg::addr_t     pc,
	input  rv_pkg::bimm_t     bimm,
	input  rv_pkg::data_t     alu_result,
	input  logic              accept,
	output pipe_pkg::branch_t branch
);

	localparam int sext_width = rv_pkg::xlen - 13;

	logic          is_branch;
	rv_pkg::addr_t offset;

	assign is_branch = insn[6:0] == rv_pkg::op_branch;

	// imm is in units of two bytes
	assign offset = {{sext_width{bimm[12]}}, bimm, 1'b0};

	always_comb begin
		branch.taken  = is_branch && (alu_result != '0); // cmp result from alu
		branch.target = pc + offset;
		branch.bubble = is_branch && accept; // one pulse per accepted branch
	end

endmodule

`default_nettype wire

// File: hdl/ex_pipe_reg.sv
`default_nettype none

module ex_pipe_reg (
	input  logic              clk,
	input  logic              reset,
	input  pipe_pkg::ex_out_t d,
	input  logic              valid_in,
	input  logic              ready_in,
	output logic              valid_out,
	output pipe_pkg::ex_out_t q
);

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
		end else if (ready_in) begin
			valid_out <= valid_in; // drops to 0 once taken with nothing new
		end
	end

	// payload follows the same enable, so a stalled item stays put
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '{pc: d.pc, default: '0}; // pc tracks fetch through reset
		end else if (ready_in) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: hdl/ex_stage.sv
`default_nettype none

module ex_stage (
	input  logic              clk,
	input  logic              reset,
	input  pipe_pkg::ex_in_t  ex_in,
	input  logic              valid_in,
	input  logic              ready_in,
	output logic              ready_out,
	output logic              valid_out,
	output pipe_pkg::ex_out_t ex_out,
	output pipe_pkg::fwd_t    fwd,
	output pipe_pkg::branch_t branch
);

	rv_pkg::data_t     alu_result;
	pipe_pkg::ex_out_t stage_out;
	logic              accept;

	assign ready_out = ready_in; // single cycle ops, never stalls
	assign accept    = valid_in && ready_out;

	ex_alu u_alu (
		.alu_op     (ex_in.alu_op),
		.src_a      (ex_in.src_a),
		.src_b      (ex_in.src_b),
		.alu_result (alu_result)
	);

	ex_branch_unit u_branch (
		.insn       (ex_in.insn),
		.pc         (ex_in.pc),
		.bimm       (ex_in.bimm),
		.alu_result (alu_result),
		.accept     (accept),
		.branch     (branch)
	);

	always_comb begin
		stage_out.pc         = ex_in.pc;
		stage_out.insn       = ex_in.insn;
		stage_out.mem_w_en   = ex_in.mem_w_en;
		stage_out.wb_sel     = ex_in.wb_sel;
		stage_out.reg_w_en   = ex_in.reg_w_en;
		stage_out.rdest      = ex_in.rdest;
		stage_out.rt_data    = ex_in.rt_data;
		stage_out.alu_result = alu_result;
	end

	// raw result, same cycle
	assign fwd = '{reg_w_en: ex_in.reg_w_en, rdest: ex_in.rdest, alu_result: alu_result};

	ex_pipe_reg u_pipe_reg (
		.clk       (clk),
		.reset     (reset),
		.d         (stage_out),
		.valid_in  (valid_in),
		.ready_in  (ready_in),
		.valid_out (valid_out),
		.q         (ex_out)
	);

endmodule

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

	// decode -> execute
	typedef struct packed {
		rv_pkg::addr_t     pc;
		rv_pkg::insn_t     insn;
		rv_pkg::alu_op_e   alu_op;
		rv_pkg::data_t     src_a;
		rv_pkg::data_t     src_b;
		rv_pkg::bimm_t     bimm;
		logic              mem_w_en;
		logic              wb_sel;   // 0 alu result, 1 mem data
		logic              reg_w_en;
		rv_pkg::reg_addr_t rdest;
		rv_pkg::data_t     rt_data;  // store data
	} ex_in_t;

	// execute -> memory
	typedef struct packed {
		rv_pkg::addr_t     pc;
		rv_pkg::insn_t     insn;
		logic              mem_w_en;
		logic              wb_sel;
		logic              reg_w_en;
		rv_pkg::reg_addr_t rdest;
		rv_pkg::data_t     rt_data;
		rv_pkg::data_t     alu_result;
	} ex_out_t;

	// bypass to decode operand muxes
	typedef struct packed {
		logic              reg_w_en;
		rv_pkg::reg_addr_t rdest;
		rv_pkg::data_t     alu_result;
	} fwd_t;

	typedef struct packed {
		logic          taken;
		rv_pkg::addr_t target;
		logic          bubble; // kills the wrong-path insn in decode
	} branch_t;

endpackage

`default_nettype wire

// File: hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen       = 64;
	localparam int word_width = 32; // *w ops work on the low half

	typedef logic [4:0]      reg_addr_t;
	typedef logic [xlen-1:0] data_t;
	typedef logic [xlen-1:0] addr_t;
	typedef logic [31:0]     insn_t;
	typedef logic [12:1]     bimm_t; // b-type imm, bit 0 implied zero

	// major opcodes, insn[6:0]
	typedef enum logic [6:0] {
		op_load   = 7'b000_0011,
		op_imm    = 7'b001_0011,
		op_auipc  = 7'b001_0111,
		op_imm_32 = 7'b001_1011,
		op_store  = 7'b010_0011,
		op_op     = 7'b011_0011,
		op_lui    = 7'b011_0111,
		op_op_32  = 7'b011_1011,
		op_branch = 7'b110_0011,
		op_jalr   = 7'b110_0111,
		op_jal    = 7'b110_1111
	} opcode_e;

	typedef enum logic [4:0] {
		alu_add  = 5'd0,
		alu_addw = 5'd1,
		alu_sll  = 5'd2,
		alu_sllw = 5'd3,
		alu_sra  = 5'd4,
		alu_sraw = 5'd5,
		alu_srl  = 5'd6,
		alu_srlw = 5'd7,
		alu_and  = 5'd8,
		alu_or   = 5'd9,
		alu_xor  = 5'd10,
		alu_slt  = 5'd11, // signed
		alu_sltu = 5'd12,
		alu_eq   = 5'd13,
		alu_ne   = 5'd14,
		alu_sge  = 5'd15, // signed
		alu_sgeu = 5'd16,
		alu_sub  = 5'd17,
		alu_subw = 5'd18
	} alu_op_e;

endpackage

`default_nettype wire

// File: tb/tb_ex_stage.sv
`default_nettype none

module tb_ex_stage;

	localparam int accept_limit = 50;
	localparam int drain_limit  = 20;

	logic              clk = 1'b0;
	logic              reset;
	pipe_pkg::ex_in_t  ex_in;
	logic              valid_in;
	logic              ready_in;
	logic              ready_out;
	logic              valid_out;
	pipe_pkg::ex_out_t ex_out;
	pipe_pkg::fwd_t    fwd;
	pipe_pkg::branch_t branch;

	pipe_pkg::ex_out_t expected_q[$];
	bit                stall_mode;
	int                stretch;

	rv_pkg::alu_op_e full_ops[14] = '{rv_pkg::alu_add, rv_pkg::alu_sub, rv_pkg::alu_sll,
		rv_pkg::alu_srl, rv_pkg::alu_sra, rv_pkg::alu_and, rv_pkg::alu_or, rv_pkg::alu_xor,
		rv_pkg::alu_slt, rv_pkg::alu_sltu, rv_pkg::alu_eq, rv_pkg::alu_ne, rv_pkg::alu_sge,
		rv_pkg::alu_sgeu};
	rv_pkg::alu_op_e word_ops[5] = '{rv_pkg::alu_addw, rv_pkg::alu_subw, rv_pkg::alu_sllw,
		rv_pkg::alu_srlw, rv_pkg::alu_sraw};
	rv_pkg::alu_op_e cmp_ops[6] = '{rv_pkg::alu_slt, rv_pkg::alu_sltu, rv_pkg::alu_eq,
		rv_pkg::alu_ne, rv_pkg::alu_sge, rv_pkg::alu_sgeu};
	rv_pkg::opcode_e mix_opcodes[4] = '{rv_pkg::op_op, rv_pkg::op_op_32, rv_pkg::op_branch,
		rv_pkg::op_load};

	ex_stage u_ex_stage (
		.clk       (clk),
		.reset     (reset),
		.ex_in     (ex_in),
		.valid_in  (valid_in),
		.ready_in  (ready_in),
		.ready_out (ready_out),
		.valid_out (valid_out),
		.ex_out    (ex_out),
		.fwd       (fwd),
		.branch    (branch)
	);

	always #5 clk = ~clk;

	function automatic rv_pkg::data_t model_alu(rv_pkg::alu_op_e op, rv_pkg::data_t a,
		rv_pkg::data_t b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [31:0]        w;
		sa = a;
		sb = b;
		w  = '0;
		case (op)
			rv_pkg::alu_add:  return a + b;
			rv_pkg::alu_sub:  return a - b;
			rv_pkg::alu_sll:  return a << b[5:0];
			rv_pkg::alu_srl:  return a >> b[5:0];
			rv_pkg::alu_sra:  return sa >>> b[5:0];
			rv_pkg::alu_and:  return a & b;
			rv_pkg::alu_or:   return a | b;
			rv_pkg::alu_xor:  return a ^ b;
			rv_pkg::alu_slt:  return {63'd0, sa < sb};
			rv_pkg::alu_sltu: return {63'd0, a < b};
			rv_pkg::alu_eq:   return {63'd0, a == b};
			rv_pkg::alu_ne:   return {63'd0, a != b};
			rv_pkg::alu_sge:  return {63'd0, !(sa < sb)};
			rv_pkg::alu_sgeu: return {63'd0, !(a < b)};
			rv_pkg::alu_addw: w = a[31:0] + b[31:0];
			rv_pkg::alu_subw: w = a[31:0] - b[31:0];
			rv_pkg::alu_sllw: w = a[31:0] << b[4:0];
			rv_pkg::alu_srlw: w = a[31:0] >> b[4:0];
			rv_pkg::alu_sraw: w = $signed(a[31:0]) >>> b[4:0];
			default:          return '0;
		endcase
		return {{32{w[31]}}, w}; // only word ops get here
	endfunction

	function automatic pipe_pkg::ex_out_t model_out(pipe_pkg::ex_in_t item);
		pipe_pkg::ex_out_t r;
		r.pc         = item.pc;
		r.insn       = item.insn;
		r.mem_w_en   = item.mem_w_en;
		r.wb_sel     = item.wb_sel;
		r.reg_w_en   = item.reg_w_en;
		r.rdest      = item.rdest;
		r.rt_data    = item.rt_data;
		r.alu_result = model_alu(item.alu_op, item.src_a, item.src_b);
		return r;
	endfunction

	function automatic pipe_pkg::fwd_t model_fwd(pipe_pkg::ex_in_t item);
		pipe_pkg::fwd_t r;
		r.reg_w_en   = item.reg_w_en;
		r.rdest      = item.rdest;
		r.alu_result = model_alu(item.alu_op, item.src_a, item.src_b);
		return r;
	endfunction

	function automatic pipe_pkg::branch_t model_branch(pipe_pkg::ex_in_t item, logic accept);
		pipe_pkg::branch_t  r;
		logic signed [63:0] off;
		logic               is_br;
		is_br    = item.insn[6:0] == rv_pkg::op_branch;
		off      = $signed({item.bimm, 1'b0}); // sign extends the 13-bit offset
		r.taken  = is_br && (model_alu(item.alu_op, item.src_a, item.src_b) != '0);
		r.target = item.pc + off;
		r.bubble = is_br && accept;
		return r;
	endfunction

	function automatic pipe_pkg::ex_in_t make_item(rv_pkg::alu_op_e op, rv_pkg::opcode_e opc);
		pipe_pkg::ex_in_t item;
		item.pc        = {$urandom, $urandom};
		item.pc[1:0]   = 2'b00;
		item.insn      = $urandom;
		item.insn[6:0] = opc;
		item.alu_op    = op;
		item.src_a     = {$urandom, $urandom};
		item.src_b     = {$urandom, $urandom};
		item.bimm      = $urandom_range(0, 4095);
		item.mem_w_en  = $urandom_range(0, 1);
		item.wb_sel    = $urandom_range(0, 1);
		item.reg_w_en  = $urandom_range(0, 1);
		item.rdest     = $urandom_range(0, 31);
		item.rt_data   = {$urandom, $urandom};
		return item;
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_problem(string what);
		$display("%s", what);
		abort_run();
	endtask

	task automatic check_out(string name, pipe_pkg::ex_out_t exp, pipe_pkg::ex_out_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_fwd(string name, pipe_pkg::fwd_t exp, pipe_pkg::fwd_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_branch(string name, pipe_pkg::branch_t exp, pipe_pkg::branch_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// random stretches of back-pressure
	task automatic drive_ready();
		if (!stall_mode) begin
			ready_in = 1'b1;
		end else begin
			if (stretch == 0) begin
				ready_in = $urandom_range(0, 1);
				stretch  = $urandom_range(1, 6);
			end
			stretch--;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		drive_ready();
	endtask

	task automatic send_item(pipe_pkg::ex_in_t item);
		bit accepted;
		int waited;
		ex_in    = item;
		valid_in = 1'b1;
		accepted = 1'b0;
		waited   = 0;
		while (!accepted) begin
			@(negedge clk);
			accepted = ready_out;
			next_cycle();
			waited++;
			if (!accepted && waited >= accept_limit) begin
				report_problem("item was never accepted by the execute stage");
			end
		end
	endtask

	// scoreboard samples mid-cycle where everything has settled
	always @(negedge clk) begin
		if (!reset) begin
			check_flag("ready_out", ready_in, ready_out);
			check_fwd("fwd", model_fwd(ex_in), fwd);
			check_branch("branch", model_branch(ex_in, valid_in && ready_in), branch);
			check_flag("valid_out", expected_q.size() != 0, valid_out);
			if (valid_out) begin
				check_out("ex_out", expected_q[0], ex_out); // held while stalled
				if (ready_in) begin
					void'(expected_q.pop_front());
				end
			end
			if (valid_in && ready_in) begin
				expected_q.push_back(model_out(ex_in));
			end
		end
	end

	initial begin
		pipe_pkg::ex_in_t item;
		int               waited;
		void'($urandom(32'hc7ab_fc75));
		reset      = 1'b1;
		ready_in   = 1'b1;
		stall_mode = 1'b0;
		stretch    = 0;
		ex_in      = make_item(rv_pkg::alu_add, rv_pkg::op_op);
		valid_in   = 1'b1; // must be ignored in reset
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_flag("valid_out", 1'b0, valid_out);
		check_out("ex_out", '{pc: ex_in.pc, default: '0}, ex_out);
		@(posedge clk);
		#1;
		reset    = 1'b0;
		valid_in = 1'b0;
		next_cycle();

		for (int i = 0; i < 60; i++) begin
			send_item(make_item(full_ops[$urandom_range(0, 13)], rv_pkg::op_op));
		end
		for (int i = 0; i < 40; i++) begin
			item = make_item(word_ops[$urandom_range(0, 4)], rv_pkg::op_op_32);
			item.src_a[31] = i[0] ? item.src_a[31] : 1'b1;
			send_item(item);
		end
		for (int i = 0; i < 40; i++) begin
			item = make_item(cmp_ops[$urandom_range(0, 5)], rv_pkg::op_branch);
			if ($urandom_range(0, 2) == 0) begin
				item.src_b = item.src_a;
			end
			send_item(item);
		end
		for (int i = 0; i < 20; i++) begin
			send_item(make_item(rv_pkg::alu_op_e'($urandom_range(19, 31)), rv_pkg::op_op));
		end

		stall_mode = 1'b1;
		for (int i = 0; i < 80; i++) begin
			item = make_item(rv_pkg::alu_op_e'($urandom_range(0, 18)),
				mix_opcodes[$urandom_range(0, 3)]);
			send_item(item);
			if ($urandom_range(0, 3) == 0) begin
				valid_in = 1'b0; // idle gap
				next_cycle();
			end
		end

		valid_in   = 1'b0;
		stall_mode = 1'b0;
		waited     = 0;
		while (expected_q.size() != 0) begin
			next_cycle();
			waited++;
			if (waited >= drain_limit) begin
				report_problem("items still pending at the end of the run");
			end
		end
		next_cycle();
		$display("All checks passed");
		$finish;
	end

endmodule

`default_nettype wire
